// File: Makefile
TOP = tb_rom_loader

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f vlog.f --top-module $(TOP) -Mdir obj_dir

# Pass only when the simulation prints the pass line
run: build
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "^RESULT: PASS$$"

lint:
	verilator --lint-only -Wall --timing -f vlog.f --top-module $(TOP)

clean:
	rm -rf obj_dir

// File: source/load_cmd_parser.sv
//////////////////////////////
// Command and header FSM with counted data phase
//////////////////////////////
module load_cmd_parser
    import loader_pkg::*;
(
    input  logic        clk,
    input  logic        reset,

    // Byte stream from the UART bridge
    input  byte_t       uart_data,
    input  logic        uart_valid,
    output logic        uart_ready,

    // Load status
    output logic        rom_busy,
    output logic        rom_done,

    // Header towards the address map
    output logic        header_valid,
    output rom_type_t   header_type,
    output rom_offset_t header_offset,

    // Data strobes towards the writer
    output logic        data_valid,
    output byte_t       data_byte
);

    typedef enum logic [3:0] {
        ST_IDLE,
        ST_TYPE,
        ST_OFS_H,
        ST_OFS_M,
        ST_OFS_L,
        ST_SIZE_H,
        ST_SIZE_M,
        ST_SIZE_L,
        ST_CMD_WAIT,
        ST_DATA,
        ST_END
    } state_t;

    state_t    state;
    rom_size_t remaining;
    logic      accept;

    // A byte moves only when both sides agree
    assign accept = uart_valid && uart_ready;

    // Header payload
    always_ff @(posedge clk) begin
        if (accept) begin
            case (state)
                ST_TYPE:  header_type          <= uart_data[2:0];
                ST_OFS_H: header_offset[23:16] <= uart_data;
                ST_OFS_M: header_offset[15:8]  <= uart_data;
                ST_OFS_L: header_offset[7:0]   <= uart_data;
                default: ;
            endcase
        end
    end

    // Data byte goes out one cycle after it is taken
    always_ff @(posedge clk) begin
        if (accept && state == ST_DATA) begin
            data_byte <= uart_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state        <= ST_IDLE;
            remaining    <= '0;
            uart_ready   <= 1'b0;
            rom_busy     <= 1'b0;
            rom_done     <= 1'b0;
            header_valid <= 1'b0;
            data_valid   <= 1'b0;
        end else begin
            // Strobes default low
            rom_done     <= 1'b0;
            header_valid <= 1'b0;
            data_valid   <= 1'b0;
            uart_ready   <= 1'b1;

            case (state)
                ST_IDLE: begin
                    // Anything but LOAD_START is dropped here
                    if (accept && uart_data == CMD_LOAD_START) begin
                        rom_busy <= 1'b1;
                        state    <= ST_TYPE;
                    end
                end

                ST_TYPE: begin
                    if (accept) state <= ST_OFS_H;
                end

                ST_OFS_H: begin
                    if (accept) state <= ST_OFS_M;
                end

                ST_OFS_M: begin
                    if (accept) state <= ST_OFS_L;
                end

                ST_OFS_L: begin
                    if (accept) state <= ST_SIZE_H;
                end

                // Size arrives high byte first
                ST_SIZE_H: begin
                    if (accept) begin
                        remaining[23:16] <= uart_data;
                        state            <= ST_SIZE_M;
                    end
                end

                ST_SIZE_M: begin
                    if (accept) begin
                        remaining[15:8] <= uart_data;
                        state           <= ST_SIZE_L;
                    end
                end

                ST_SIZE_L: begin
                    if (accept) begin
                        remaining[7:0] <= uart_data;
                        header_valid   <= 1'b1;
                        state          <= ST_CMD_WAIT;
                    end
                end

                ST_CMD_WAIT: begin
                    if (accept) begin
                        case (uart_data)
                            CMD_LOAD_DATA: begin
                                // Nothing left to take, so stay put
                                if (remaining != '0) state <= ST_DATA;
                            end
                            CMD_LOAD_END: begin
                                rom_busy   <= 1'b0;
                                rom_done   <= 1'b1;
                                uart_ready <= 1'b0;
                                state      <= ST_END;
                            end
                            CMD_LOAD_ABORT: begin
                                rom_busy <= 1'b0;
                                state    <= ST_IDLE;
                            end
                            default: ;
                        endcase
                    end
                end

                ST_DATA: begin
                    // Every byte here is data, even a command code
                    if (accept) begin
                        data_valid <= 1'b1;
                        remaining  <= remaining - 1'b1;
                        if (remaining == rom_size_t'(1)) state <= ST_CMD_WAIT;
                    end
                end

                // Ready drops for the one cycle of the done pulse
                ST_END: begin
                    state <= ST_IDLE;
                end

                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

endmodule

// File: source/loader_pkg.sv
//////////////////////////////
// Loader types, command codes, SDRAM base map
// and .NEO region bounds
//////////////////////////////
package loader_pkg;

    // Widths used across the loader
    typedef logic [7:0]  byte_t;
    typedef logic [24:0] sdram_addr_t;
    typedef logic [23:0] rom_offset_t;
    typedef logic [23:0] rom_size_t;
    typedef logic [2:0]  rom_type_t;

    // ROM type codes as sent in the header
    localparam rom_type_t ROM_BIOS = 3'd0;
    localparam rom_type_t ROM_P    = 3'd1;
    localparam rom_type_t ROM_S    = 3'd2;
    localparam rom_type_t ROM_M    = 3'd3;
    localparam rom_type_t ROM_V    = 3'd4;
    localparam rom_type_t ROM_C    = 3'd5;
    // Single-file image split by offset region
    localparam rom_type_t ROM_NEO  = 3'd6;

    // SDRAM base address of each ROM region
    localparam sdram_addr_t ADDR_BIOS = 25'h0000000;
    localparam sdram_addr_t ADDR_P    = 25'h0020000;
    localparam sdram_addr_t ADDR_C    = 25'h0100000;
    localparam sdram_addr_t ADDR_V    = 25'h0200000;
    localparam sdram_addr_t ADDR_M    = 25'h0280000;
    localparam sdram_addr_t ADDR_S    = 25'h0300000;

    // Region starts inside a .NEO image
    // Offsets below NEO_C_START belong to the P ROM
    localparam rom_offset_t NEO_C_START = 24'h100000;
    localparam rom_offset_t NEO_V_START = 24'h200000;
    localparam rom_offset_t NEO_M_START = 24'h300000;
    localparam rom_offset_t NEO_S_START = 24'h380000;

    // UART protocol command bytes
    localparam byte_t CMD_LOAD_START = 8'h01;
    localparam byte_t CMD_LOAD_DATA  = 8'h02;
    localparam byte_t CMD_LOAD_END   = 8'h03;
    localparam byte_t CMD_LOAD_ABORT = 8'h04;

endpackage

// File: source/rom_address_map.sv
//////////////////////////////
// ROM type and offset to SDRAM start address
//////////////////////////////
module rom_address_map
    import loader_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        header_valid,
    input  rom_type_t   header_type,
    input  rom_offset_t header_offset,
    output sdram_addr_t start_addr,
    output logic        start_valid
);

    sdram_addr_t base;
    rom_offset_t rel_offset;
    sdram_addr_t next_addr;

    // Base by type; .NEO picks base and offset by region
    always_comb begin
        rel_offset = header_offset;
        case (header_type)
            ROM_BIOS: base = ADDR_BIOS;
            ROM_P:    base = ADDR_P;
            ROM_S:    base = ADDR_S;
            ROM_M:    base = ADDR_M;
            ROM_V:    base = ADDR_V;
            ROM_C:    base = ADDR_C;
            ROM_NEO: begin
                if (header_offset < NEO_C_START) begin
                    base = ADDR_P;
                end else if (header_offset < NEO_V_START) begin
                    base       = ADDR_C;
                    rel_offset = header_offset - NEO_C_START;
                end else if (header_offset < NEO_M_START) begin
                    base       = ADDR_V;
                    rel_offset = header_offset - NEO_V_START;
                end else if (header_offset < NEO_S_START) begin
                    base       = ADDR_M;
                    rel_offset = header_offset - NEO_M_START;
                end else begin
                    base       = ADDR_S;
                    rel_offset = header_offset - NEO_S_START;
                end
            end
            default: base = '0;
        endcase
    end

    // Wraps in 25 bits
    assign next_addr = base + sdram_addr_t'(rel_offset);

    always_ff @(posedge clk) begin
        if (header_valid) start_addr <= next_addr;
    end

    always_ff @(posedge clk) begin
        if (reset) start_valid <= 1'b0;
        else       start_valid <= header_valid;
    end

endmodule

// File: source/rom_loader.sv
//////////////////////////////
// ROM loader top level from UART byte stream to SDRAM
//////////////////////////////
module rom_loader
    import loader_pkg::*;
(
    input  logic        clk,
    input  logic        reset,

    // UART bridge side
    input  byte_t       uart_data,
    input  logic        uart_valid,
    output logic        uart_ready,

    // Status
    output logic        rom_busy,
    output logic        rom_done,

    // SDRAM side
    output sdram_addr_t sdram_addr,
    output byte_t       sdram_data,
    output logic        sdram_wr
);

    // Parser to address map
    logic        header_valid;
    rom_type_t   header_type;
    rom_offset_t header_offset;

    // Address map to writer
    sdram_addr_t start_addr;
    logic        start_valid;

    // Parser to writer
    logic        data_valid;
    byte_t       data_byte;

    load_cmd_parser parser0 (
        .clk           (clk),
        .reset         (reset),
        .uart_data     (uart_data),
        .uart_valid    (uart_valid),
        .uart_ready    (uart_ready),
        .rom_busy      (rom_busy),
        .rom_done      (rom_done),
        .header_valid  (header_valid),
        .header_type   (header_type),
        .header_offset (header_offset),
        .data_valid    (data_valid),
        .data_byte     (data_byte)
    );

    rom_address_map map0 (
        .clk           (clk),
        .reset         (reset),
        .header_valid  (header_valid),
        .header_type   (header_type),
        .header_offset (header_offset),
        .start_addr    (start_addr),
        .start_valid   (start_valid)
    );

    sdram_byte_writer writer0 (
        .clk           (clk),
        .reset         (reset),
        .start_addr    (start_addr),
        .start_valid   (start_valid),
        .data_byte     (data_byte),
        .data_valid    (data_valid),
        .sdram_addr    (sdram_addr),
        .sdram_data    (sdram_data),
        .sdram_wr      (sdram_wr)
    );

endmodule

// File: source/sdram_byte_writer.sv
//////////////////////////////
// Address counter and SDRAM write port
//////////////////////////////
module sdram_byte_writer
    import loader_pkg::*;
(
    input  logic        clk,
    input  logic        reset,

    // Start address from the map
    input  sdram_addr_t start_addr,
    input  logic        start_valid,

    // Data bytes from the parser
    input  byte_t       data_byte,
    input  logic        data_valid,

    // SDRAM write port without back-pressure
    output sdram_addr_t sdram_addr,
    output byte_t       sdram_data,
    output logic        sdram_wr
);

    sdram_addr_t addr_cnt;

    // Next write address
    always_ff @(posedge clk) begin
        if (reset) begin
            addr_cnt <= '0;
        end else if (start_valid) begin
            addr_cnt <= start_addr;
        end else if (data_valid) begin
            addr_cnt <= addr_cnt + 1'b1;
        end
    end

    // Port registers only load with a write
    always_ff @(posedge clk) begin
        if (data_valid) begin
            sdram_addr <= addr_cnt;
            sdram_data <= data_byte;
        end
    end

    // One strobe per byte
    always_ff @(posedge clk) begin
        if (reset) sdram_wr <= 1'b0;
        else       sdram_wr <= data_valid;
    end

endmodule

// File: testbench/rom_loader_sva.sv
//////////////////////////////
// Assertions on loader status and SDRAM port
//////////////////////////////
module rom_loader_sva
    import loader_pkg::*;
(
    input logic        clk,
    input logic        reset,
    input logic        uart_ready,
    input logic        rom_busy,
    input logic        rom_done,
    input sdram_addr_t sdram_addr,
    input byte_t       sdram_data,
    input logic        sdram_wr
);

    // Done is a single-cycle pulse
    done_pulse: assert property (@(posedge clk) disable iff (reset) rom_done |=> !rom_done)
        else $error("rom_done stayed high for more than one cycle");

    done_not_busy: assert property (@(posedge clk) disable iff (reset) rom_done |-> !rom_busy)
        else $error("rom_busy high together with rom_done");

    // The recovery cycle
    done_not_ready: assert property (@(posedge clk) disable iff (reset) rom_done |-> !uart_ready)
        else $error("uart_ready high together with rom_done");

    write_known: assert property (@(posedge clk) disable iff (reset)
        sdram_wr |-> !$isunknown({sdram_addr, sdram_data}))
        else $error("SDRAM write with unknown address or data");

endmodule

bind rom_loader rom_loader_sva sva0 (
    .clk        (clk),
    .reset      (reset),
    .uart_ready (uart_ready),
    .rom_busy   (rom_busy),
    .rom_done   (rom_done),
    .sdram_addr (sdram_addr),
    .sdram_data (sdram_data),
    .sdram_wr   (sdram_wr)
);

// File: testbench/tb_clock_gen.sv
//////////////////////////////
// Testbench clock and reset
//////////////////////////////
module tb_clock_gen (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Reset held over the first 4 rising edges
    initial begin
        reset = 1'b1;
        repeat (4) @(posedge clk);
        #10 reset = 1'b0;
    end

endmodule

// File: testbench/tb_rom_loader.sv
//////////////////////////////
// ROM loader testbench with reference map,
// write monitor and timeout
//////////////////////////////
module tb_rom_loader
    import loader_pkg::*;
();

    // Upper bound on bytes sent and worst cycles per byte
    localparam int TOTAL_BYTES = 400;
    localparam int MAX_GAP     = 3;
    localparam int CYCLE_LIMIT = TOTAL_BYTES * (MAX_GAP + 2) + 300;

    logic        clk;
    logic        reset;
    byte_t       uart_data;
    logic        uart_valid;
    logic        uart_ready;
    logic        rom_busy;
    logic        rom_done;
    sdram_addr_t sdram_addr;
    byte_t       sdram_data;
    logic        sdram_wr;

    logic [31:0] lfsr_state = 32'h5c06;
    sdram_addr_t exp_addr_q[$];
    byte_t       exp_data_q[$];
    byte_t       payload[$];
    int          errors      = 0;
    int          writes_seen = 0;
    int          cycles      = 0;

    // Offsets inside each .NEO region and on both sides of every bound
    rom_offset_t neo_offsets [10] = '{24'h000000, 24'h0FFFFF, NEO_C_START, 24'h1FFFFF,
        NEO_V_START, 24'h2FFFFF, NEO_M_START, 24'h37FFFF, NEO_S_START, 24'hFFFFF0};

    tb_clock_gen clk_gen0 (.clk (clk), .reset (reset));

    rom_loader dut0 (
        .clk        (clk),
        .reset      (reset),
        .uart_data  (uart_data),
        .uart_valid (uart_valid),
        .uart_ready (uart_ready),
        .rom_busy   (rom_busy),
        .rom_done   (rom_done),
        .sdram_addr (sdram_addr),
        .sdram_data (sdram_data),
        .sdram_wr   (sdram_wr)
    );

    // Fibonacci LFSR with taps 32 22 2 1 and one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        int          i;
        v = '0;
        for (i = 0; i < n; i++) begin
            lfsr_state = {lfsr_state[30:0],
                          lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    // Expected start address from type and offset
    function automatic sdram_addr_t ref_start_addr(input rom_type_t t, input rom_offset_t ofs);
        sdram_addr_t base;
        rom_offset_t region;
        region = '0;
        case (t)
            ROM_BIOS: base = ADDR_BIOS;
            ROM_P:    base = ADDR_P;
            ROM_S:    base = ADDR_S;
            ROM_M:    base = ADDR_M;
            ROM_V:    base = ADDR_V;
            ROM_C:    base = ADDR_C;
            ROM_NEO: begin
                // Highest region first
                if (ofs >= NEO_S_START) begin
                    base   = ADDR_S;
                    region = NEO_S_START;
                end else if (ofs >= NEO_M_START) begin
                    base   = ADDR_M;
                    region = NEO_M_START;
                end else if (ofs >= NEO_V_START) begin
                    base   = ADDR_V;
                    region = NEO_V_START;
                end else if (ofs >= NEO_C_START) begin
                    base   = ADDR_C;
                    region = NEO_C_START;
                end else begin
                    base = ADDR_P;
                end
            end
            default: base = '0;
        endcase
        return base + sdram_addr_t'(ofs - region);
    endfunction

    task automatic check_addr(input string name, input sdram_addr_t exp, input sdram_addr_t act);
        if (act !== exp) begin
            errors++;
            $display("Error at %0t: %s expected %h, got %h", $time, name, exp, act);
        end
    endtask

    task automatic check_data(input string name, input byte_t exp, input byte_t act);
        if (act !== exp) begin
            errors++;
            $display("Error at %0t: %s expected %h, got %h", $time, name, exp, act);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            errors++;
            $display("Error at %0t: %s expected %b, got %b", $time, name, exp, act);
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (act != exp) begin
            errors++;
            $display("Error at %0t: %s expected %0d, got %0d", $time, name, exp, act);
        end
    endtask

    // Each wait ends 10 units after a rising edge
    task automatic wait_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #10;
        end
    endtask

    task automatic send_byte(input byte_t b);
        int   gap;
        logic taken;
        gap = int'(rand_bits(2));
        wait_cycles(gap);
        uart_data  = b;
        uart_valid = 1'b1;
        do begin
            taken = uart_ready;
            wait_cycles(1);
        end while (!taken);
        uart_valid = 1'b0;
    endtask

    task automatic fill_random(input int n);
        payload.delete();
        repeat (n) payload.push_back(byte_t'(rand_bits(8)));
    endtask

    // Full load of payload; pause_at > 0 adds an idle stretch mid-block
    // and a surplus LOAD_DATA after the last byte
    task automatic run_load(input rom_type_t t, input rom_offset_t ofs, input logic send_data,
                            input int pause_at, input byte_t finish_cmd);
        sdram_addr_t start;
        rom_size_t   size;
        int          base_cnt;
        int          i;
        start    = ref_start_addr(t, ofs);
        size     = rom_size_t'(payload.size());
        base_cnt = writes_seen;
        send_byte(CMD_LOAD_START);
        check_bit("rom_busy", 1'b1, rom_busy);
        send_byte(byte_t'(t));
        send_byte(ofs[23:16]);
        send_byte(ofs[15:8]);
        send_byte(ofs[7:0]);
        send_byte(size[23:16]);
        send_byte(size[15:8]);
        send_byte(size[7:0]);
        if (send_data) begin
            send_byte(CMD_LOAD_DATA);
            for (i = 0; i < payload.size(); i++) begin
                if (pause_at > 0 && i == pause_at) wait_cycles(8);
                exp_addr_q.push_back(start + sdram_addr_t'(i));
                exp_data_q.push_back(payload[i]);
                send_byte(payload[i]);
            end
            if (pause_at > 0) send_byte(CMD_LOAD_DATA);
        end
        check_bit("rom_busy", 1'b1, rom_busy);
        send_byte(finish_cmd);
        check_bit("rom_busy", 1'b0, rom_busy);
        check_bit("rom_done", finish_cmd == CMD_LOAD_END, rom_done);
        check_bit("uart_ready", finish_cmd != CMD_LOAD_END, uart_ready);
        wait_cycles(1);
        check_bit("rom_done", 1'b0, rom_done);
        check_bit("uart_ready", 1'b1, uart_ready);
        wait_cycles(2);
        check_count("pending writes", 0, exp_addr_q.size());
        check_count("write count", send_data ? payload.size() : 0, writes_seen - base_cnt);
    endtask

    // Write monitor samples mid-cycle where the port is stable
    always @(negedge clk) begin
        if (!reset && sdram_wr === 1'b1) begin
            writes_seen++;
            if (exp_addr_q.size() == 0) begin
                errors++;
                $display("Unexpected SDRAM write at %0t to address %h", $time, sdram_addr);
            end else begin
                check_addr("sdram_addr", exp_addr_q.pop_front(), sdram_addr);
                check_data("sdram_data", exp_data_q.pop_front(), sdram_data);
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout, run still going after %0d cycles", CYCLE_LIMIT);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    initial begin
        rom_type_t t;
        int        i;
        uart_data  = '0;
        uart_valid = 1'b0;

        // Quiet outputs during reset
        wait_cycles(2);
        check_bit("uart_ready", 1'b0, uart_ready);
        check_bit("rom_busy", 1'b0, rom_busy);
        check_bit("rom_done", 1'b0, rom_done);
        check_bit("sdram_wr", 1'b0, sdram_wr);
        wait (!reset);
        wait_cycles(1);
        check_bit("uart_ready", 1'b1, uart_ready);

        // Idle ignores everything but LOAD_START
        send_byte(CMD_LOAD_DATA);
        send_byte(CMD_LOAD_END);
        send_byte(CMD_LOAD_ABORT);
        send_byte(8'hA5);
        wait_cycles(3);
        check_bit("rom_busy", 1'b0, rom_busy);
        check_count("write count", 0, writes_seen);

        // One load per plain type
        for (t = ROM_BIOS; t <= ROM_C; t++) begin
            fill_random(1 + int'(rand_bits(4)));
            run_load(t, rom_offset_t'(rand_bits(20)), 1'b1, 0, CMD_LOAD_END);
        end

        // .NEO region decode
        for (i = 0; i < 10; i++) begin
            fill_random(2);
            run_load(ROM_NEO, neo_offsets[i], 1'b1, 0, CMD_LOAD_END);
        end

        // Abort before any data, then after a full block
        fill_random(6);
        run_load(ROM_M, 24'h004000, 1'b0, 0, CMD_LOAD_ABORT);
        fill_random(5);
        run_load(ROM_S, 24'h000080, 1'b1, 0, CMD_LOAD_ABORT);

        // Command codes inside the data are plain data
        fill_random(16);
        payload[3]  = CMD_LOAD_START;
        payload[4]  = CMD_LOAD_DATA;
        payload[9]  = CMD_LOAD_END;
        payload[10] = CMD_LOAD_ABORT;
        run_load(ROM_V, 24'h00F000, 1'b1, 8, CMD_LOAD_END);

        $display("Finished with %0d errors", errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: vlog.f
source/loader_pkg.sv
source/load_cmd_parser.sv
source/rom_address_map.sv
source/sdram_byte_writer.sv
source/rom_loader.sv
testbench/tb_clock_gen.sv
testbench/rom_loader_sva.sv
testbench/tb_rom_loader.sv
